// ==== source/fetchPkg.sv ====
package fetchPkg;

    // where fetch goes on an exception.
    localparam logic [15:0] excVector = 16'h0002;

    // one instruction handed to decode.
    typedef struct packed {
        // raw instruction word.
        logic [15:0] instruction;
        // byte address it was fetched from.
        logic [15:0] pc;
        // pc plus two.
        logic [15:0] incPc;
        // set when no fill was needed.
        logic        cacheHit;
    } fetchPacketT;

    // controls coming back from later stages.
    typedef struct packed {
        logic        branchJumpTaken;
        // target of a taken branch or jump.
        logic [15:0] branchPc;
        logic        exception;
        // return from interrupt.
        logic        rti;
        logic        halt;
    } redirectT;

endpackage

// ==== source/memPkg.sv ====
package memPkg;

    // line fill request from the cache.
    typedef struct packed {
        // one cycle pulse per fill.
        logic        valid;
        // word address, byte bit dropped.
        logic [14:0] addr;
    } memReqT;

    // fill response from the backing ROM.
    typedef struct packed {
        // one cycle pulse with the data.
        logic        valid;
        logic [15:0] data;
    } memRspT;

    // no handshake on this path.
    // only one fill is ever in flight,
    // and the answer comes a fixed
    // number of cycles after the request.

endpackage

// ==== source/pcControl.sv ====
`timescale 1ns/100ps

module pcControl (
    input  logic               clk,
    input  logic               arstN,
    input  fetchPkg::redirectT redirect,
    input  logic               advance,
    output logic [15:0]        pc,
    output logic [15:0]        incPc
);

    // saved return address.
    logic [15:0] epc;
    // set between an exception and its rti.
    logic        excState;

    logic [15:0] nextPc;
    logic [15:0] nextEpc;
    logic        nextExcState;

    // sequential successor, also saved into epc.
    assign incPc = pc + 16'd2;

    // next-pc priority, first match wins.
    always_comb begin
        nextPc       = pc;
        nextEpc      = epc;
        nextExcState = excState;
        if (redirect.exception) begin
            // jump to the vector and remember where to come back.
            nextPc       = fetchPkg::excVector;
            nextEpc      = incPc;
            nextExcState = 1'b1;
        end else if (redirect.rti && excState) begin
            // resume at the saved address.
            nextPc       = epc;
            nextExcState = 1'b0;
        end else if (redirect.branchJumpTaken) begin
            nextPc = redirect.branchPc;
        end else if (redirect.halt) begin
            // hold while halted.
            nextPc = pc;
        end else if (advance) begin
            // current instruction issued, step on.
            nextPc = incPc;
        end
        // rti outside exception state falls through and is ignored.
    end

    // pc, epc and exception flag.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc       <= 16'h0000;
            epc      <= 16'h0000;
            excState <= 1'b0;
        end else begin
            pc       <= nextPc;
            epc      <= nextEpc;
            excState <= nextExcState;
        end
    end

endmodule

// ==== source/instrCache.sv ====
`timescale 1ns/100ps

module instrCache #(
    parameter int CacheLines = 16
) (
    input  logic             clk,
    input  logic             arstN,
    input  logic [15:0]      pc,
    output logic             hit,
    output logic [15:0]      rdData,
    output memPkg::memReqT   memReq,
    input  memPkg::memRspT   memRsp
);

    // index from the low word-address bits.
    localparam int IndexW = $clog2(CacheLines);
    // tag is the rest of the word address.
    localparam int TagW   = 15 - IndexW;

    typedef enum logic {
        stateIdle,
        stateWait
    } stateT;

    stateT state;
    stateT nextState;

    // line storage, one word per line.
    logic [15:0]     dataMem [CacheLines];
    logic [TagW-1:0] tagMem  [CacheLines];
    // per-line valid bits.
    logic [CacheLines-1:0] lineValid;

    // word address of the fill in flight.
    logic [14:0] fillAddr;

    logic [14:0]       wordAddr;
    logic [IndexW-1:0] pcIndex;
    logic [TagW-1:0]   pcTag;
    logic [IndexW-1:0] fillIndex;
    logic [TagW-1:0]   fillTag;

    // split the current pc.
    assign wordAddr = pc[15:1];
    assign pcIndex  = wordAddr[IndexW-1:0];
    assign pcTag    = wordAddr[14:IndexW];

    // split the fill address the same way.
    assign fillIndex = fillAddr[IndexW-1:0];
    assign fillTag   = fillAddr[14:IndexW];

    // lookup.
    // a hit may come during a fill too, after a redirect to a cached line.
    assign hit    = lineValid[pcIndex] && (tagMem[pcIndex] == pcTag);
    assign rdData = dataMem[pcIndex];

    // request goes out in the first miss cycle.
    // only from idle, so never two fills at once.
    assign memReq.valid = (state == stateIdle) && !hit;
    assign memReq.addr  = wordAddr;

    // miss state machine.
    always_comb begin
        nextState = state;
        case (state)
            stateIdle: begin
                if (!hit) begin
                    nextState = stateWait;
                end
            end
            stateWait: begin
                // back to idle, then compare against the pc of that time.
                if (memRsp.valid) begin
                    nextState = stateIdle;
                end
            end
            default: nextState = stateIdle;
        endcase
    end

    // state and valid bits.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= stateIdle;
            lineValid <= '0;
        end else begin
            state <= nextState;
            if (state == stateWait && memRsp.valid) begin
                lineValid[fillIndex] <= 1'b1;
            end
        end
    end

    // fill address, taken with the request.
    // pc may move on while the fill is out.
    always_ff @(posedge clk) begin
        if (memReq.valid) begin
            fillAddr <= wordAddr;
        end
    end

    // line write on the response.
    always_ff @(posedge clk) begin
        if (state == stateWait && memRsp.valid) begin
            dataMem[fillIndex] <= memRsp.data;
            tagMem[fillIndex]  <= fillTag;
        end
    end

endmodule

// ==== source/instrBacking.sv ====
`timescale 1ns/100ps

module instrBacking #(
    parameter int MemLatency = 4,
    parameter int RomWords   = 32
) (
    input  logic           clk,
    input  logic           arstN,
    input  memPkg::memReqT memReq,
    output memPkg::memRspT memRsp
);

    localparam int IdxW = $clog2(RomWords);
    // wide enough to hold MemLatency - 1.
    localparam int CntW = $clog2(MemLatency + 1);

    // program image.
    logic [15:0] rom [RomWords];

    initial begin
        $readmemh("instrRom.hex", rom);
    end

    // set while a fill is counting down.
    logic            busy;
    logic [CntW-1:0] cnt;
    // rom index, wraps on the low word-address bits.
    logic [IdxW-1:0] romIdx;

    // answer exactly MemLatency cycles after the request cycle.
    assign memRsp.valid = busy && (cnt == '0);
    assign memRsp.data  = rom[romIdx];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (!busy && memReq.valid) begin
            busy <= 1'b1;
            cnt  <= CntW'(MemLatency - 1);
        end else if (busy) begin
            // done after the response cycle.
            if (cnt == '0) begin
                busy <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // address capture, no reset needed.
    always_ff @(posedge clk) begin
        if (!busy && memReq.valid) begin
            romIdx <= memReq.addr[IdxW-1:0];
        end
    end

endmodule

// ==== source/fetchIssue.sv ====
`timescale 1ns/100ps

module fetchIssue #(
    parameter int CreditDepth = 4
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  hit,
    input  logic [15:0]           rdData,
    input  logic [15:0]           pc,
    input  logic [15:0]           incPc,
    input  fetchPkg::redirectT    redirect,
    input  logic                  creditReturn,
    output logic                  advance,
    output logic                  pktValid,
    output fetchPkg::fetchPacketT pkt
);

    localparam int CredW = $clog2(CreditDepth + 1);

    // credits decode still has room for.
    logic [CredW-1:0] credits;
    // any redirect control this cycle.
    logic             redirectAny;
    // pc and hit of the cycle before.
    logic [15:0]      prevPc;
    logic             prevHit;
    // line was already valid before this hit.
    logic             lineWasValid;

    assign redirectAny = redirect.branchJumpTaken | redirect.exception |
                         redirect.rti | redirect.halt;

    // issue the current pc's instruction.
    assign advance = hit && (credits != '0) && !redirectAny;

    // a miss on this same pc last cycle means a fill was needed.
    assign lineWasValid = (pc != prevPc) || prevHit;

    // credit counter, down on issue and up on return.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            credits <= CredW'(CreditDepth);
        end else begin
            credits <= credits - CredW'(advance) + CredW'(creditReturn);
        end
    end

    // history for the cacheHit flag.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            prevPc  <= 16'h0000;
            prevHit <= 1'b0;
        end else begin
            prevPc  <= pc;
            prevHit <= hit;
        end
    end

    // packet valid one cycle after advance.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pktValid <= 1'b0;
        end else begin
            pktValid <= advance;
        end
    end

    // payload only.
    always_ff @(posedge clk) begin
        if (advance) begin
            pkt.instruction <= rdData;
            pkt.pc          <= pc;
            pkt.incPc       <= incPc;
            pkt.cacheHit    <= lineWasValid;
        end
    end

endmodule

// ==== source/fetchTop.sv ====
`timescale 1ns/100ps

module fetchTop #(
    parameter int CacheLines  = 16,
    parameter int MemLatency  = 4,
    parameter int RomWords    = 32,
    parameter int CreditDepth = 4
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  fetchPkg::redirectT    redirect,
    input  logic                  creditReturn,
    output logic                  pktValid,
    output fetchPkg::fetchPacketT pkt
);

    // pc path.
    logic [15:0] pc;
    logic [15:0] incPc;
    logic        advance;

    // cache lookup result.
    logic        hit;
    logic [15:0] rdData;

    // fill path.
    memPkg::memReqT memReq;
    memPkg::memRspT memRsp;

    pcControl pcControl_i (
        .clk      (clk),
        .arstN    (arstN),
        .redirect (redirect),
        .advance  (advance),
        .pc       (pc),
        .incPc    (incPc)
    );

    instrCache #(
        .CacheLines (CacheLines)
    ) instrCache_i (
        .clk    (clk),
        .arstN  (arstN),
        .pc     (pc),
        .hit    (hit),
        .rdData (rdData),
        .memReq (memReq),
        .memRsp (memRsp)
    );

    // multi-cycle ROM behind the cache.
    instrBacking #(
        .MemLatency (MemLatency),
        .RomWords   (RomWords)
    ) instrBacking_i (
        .clk    (clk),
        .arstN  (arstN),
        .memReq (memReq),
        .memRsp (memRsp)
    );

    fetchIssue #(
        .CreditDepth (CreditDepth)
    ) fetchIssue_i (
        .clk          (clk),
        .arstN        (arstN),
        .hit          (hit),
        .rdData       (rdData),
        .pc           (pc),
        .incPc        (incPc),
        .redirect     (redirect),
        .creditReturn (creditReturn),
        .advance      (advance),
        .pktValid     (pktValid),
        .pkt          (pkt)
    );

endmodule

// ==== tb/fetchTb.sv ====
`timescale 1ns/100ps

module fetchTb;

    localparam int CacheLines  = 16;
    localparam int MemLatency  = 4;
    localparam int RomWords    = 32;
    localparam int CreditDepth = 4;
    // six stimulus phases, each with a budget of 2000 cycles.
    localparam int PhaseCount  = 6;
    localparam int ClkPeriod   = 8;
    localparam int IndexW      = $clog2(CacheLines);
    localparam int RomIdxW     = $clog2(RomWords);

    logic                  clk = 1'b0;
    logic                  arstN;
    fetchPkg::redirectT    redirect;
    logic                  creditReturn = 1'b0;
    logic                  pktValid;
    fetchPkg::fetchPacketT pkt;

    // expected program image.
    logic [15:0] romImage [RomWords];

    // reference pc, return address and exception flag.
    logic [15:0] refPc  = 16'h0000;
    logic [15:0] refEpc = 16'h0000;
    logic        refExc = 1'b0;

    // which words the cache holds, and the fill in flight.
    logic [CacheLines-1:0] modelValid = '0;
    logic [14-IndexW:0]    modelTag [CacheLines];
    logic                  fillBusy = 1'b0;
    int                    fillCnt  = 0;
    logic [15:0]           fillPc   = 16'h0000;

    // lookup of the cycle before, and the fill that ended then.
    logic        prevHit      = 1'b0;
    logic        justFilled   = 1'b0;
    logic [15:0] justFilledPc = 16'h0000;
    logic        expCacheHit  = 1'b0;
    logic        controlPrev  = 1'b0;

    // decode side.
    fetchPkg::fetchPacketT rxQueue [$];
    logic                  withhold;
    logic [31:0]           rngState    = 32'hf7c524f1;
    int                    creditDelay = 0;

    int pktCount    = 0;
    int retCount    = 0;
    int hitPackets  = 0;
    int fillPackets = 0;
    int hitsBeforeLoop;

    fetchTop #(
        .CacheLines  (CacheLines),
        .MemLatency  (MemLatency),
        .RomWords    (RomWords),
        .CreditDepth (CreditDepth)
    ) fetchTop_i (
        .clk          (clk),
        .arstN        (arstN),
        .redirect     (redirect),
        .creditReturn (creditReturn),
        .pktValid     (pktValid),
        .pkt          (pkt)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    initial begin
        $readmemh("instrRom.hex", romImage);
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // rom word at a byte address, wrapping on the rom size.
    function automatic logic [15:0] romWord(input logic [15:0] addr);
        return romImage[addr[RomIdxW:1]];
    endfunction

    // index from the low word bits, tag from the rest.
    function automatic logic lineHeld(input logic [15:0] addr);
        return modelValid[addr[IndexW:1]] &&
               (modelTag[addr[IndexW:1]] == addr[15:IndexW+1]);
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic expectEqual(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual == expected) else begin
            abortRun($sformatf("ERROR %s expected 0x%h actual 0x%h", name, expected, actual));
        end
    endtask

    task automatic ensureThat(input logic cond, input string why);
        assert (cond) else begin
            abortRun(why);
        end
    endtask

    // one cycle of the reference model, sampled mid-cycle.
    task automatic observeCycle();
        logic hitNow;
        // packet from the advance of the cycle before.
        if (pktValid) begin
            ensureThat(!controlPrev, "a packet was issued right after a redirect control");
            ensureThat(prevHit, "a packet was issued for a word the cache could not hold");
            expectEqual("pkt.pc", refPc, pkt.pc);
            expectEqual("pkt.incPc", refPc + 16'd2, pkt.incPc);
            expectEqual("pkt.instruction", romWord(refPc), pkt.instruction);
            expectEqual("pkt.cacheHit", {15'd0, expCacheHit}, {15'd0, pkt.cacheHit});
            if (pkt.cacheHit) begin
                hitPackets++;
            end else begin
                fillPackets++;
            end
            pktCount++;
            rxQueue.push_back(pkt);
            refPc = refPc + 16'd2;
        end
        ensureThat(pktCount - retCount <= CreditDepth, "more packets outstanding than credits");
        // refPc now holds this cycle's pc.
        hitNow = lineHeld(refPc);
        // a word written by the fill that ended last cycle was not held then.
        expCacheHit = !(justFilled && (justFilledPc == refPc));
        prevHit     = hitNow;
        justFilled  = 1'b0;
        // fill answers MemLatency cycles after the request cycle.
        if (fillBusy) begin
            if (fillCnt == 0) begin
                modelValid[fillPc[IndexW:1]] = 1'b1;
                modelTag[fillPc[IndexW:1]]   = fillPc[15:IndexW+1];
                fillBusy                     = 1'b0;
                justFilled                   = 1'b1;
                justFilledPc                 = fillPc;
            end else begin
                fillCnt--;
            end
        end else if (!hitNow) begin
            fillBusy = 1'b1;
            fillCnt  = MemLatency - 1;
            fillPc   = refPc;
        end
        // next-pc priority.
        if (redirect.exception) begin
            refEpc = refPc + 16'd2;
            refPc  = 16'h0002;
            refExc = 1'b1;
        end else if (redirect.rti && refExc) begin
            refPc  = refEpc;
            refExc = 1'b0;
        end else if (redirect.branchJumpTaken) begin
            refPc = redirect.branchPc;
        end
        controlPrev = redirect.branchJumpTaken | redirect.exception |
                      redirect.rti | redirect.halt;
        if (creditReturn) begin
            retCount++;
        end
    endtask

    always @(negedge clk) begin
        if (arstN) begin
            observeCycle();
        end
    end

    // decode consumes a packet and returns its credit after a random delay.
    always begin
        @(posedge clk);
        #1;
        creditReturn = 1'b0;
        if (arstN && !withhold && rxQueue.size() > 0) begin
            if (creditDelay == 0) begin
                void'(rxQueue.pop_front());
                creditReturn = 1'b1;
                rngState     = xorshift(rngState);
                creditDelay  = int'(rngState[2:0]);
            end else begin
                creditDelay--;
            end
        end
    end

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic waitPackets(input int n);
        int target;
        target = pktCount + n;
        while (pktCount < target) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic branchTo(input logic [15:0] target);
        redirect.branchJumpTaken = 1'b1;
        redirect.branchPc        = target;
        idleCycles(1);
        redirect = '0;
    endtask

    task automatic raiseException();
        redirect.exception = 1'b1;
        idleCycles(1);
        redirect = '0;
    endtask

    task automatic returnFromInterrupt();
        redirect.rti = 1'b1;
        idleCycles(1);
        redirect = '0;
    endtask

    initial begin
        arstN    = 1'b0;
        redirect = '0;
        withhold = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        arstN = 1'b1;

        // sequential fetch from reset.
        waitPackets(12);

        // decode holds every packet, so credits run out.
        @(negedge clk);
        withhold = 1'b1;
        idleCycles(60);
        ensureThat(pktCount - retCount == CreditDepth, "credits never ran out during the stall");
        @(negedge clk);
        withhold = 1'b0;
        waitPackets(8);

        // branch to a new line, then redirect twice while fills are out.
        branchTo(16'h0050);
        waitPackets(3);
        branchTo(16'h007a);
        idleCycles(2);
        branchTo(16'h000c);
        waitPackets(4);

        // rti outside exception state is ignored.
        returnFromInterrupt();
        waitPackets(2);
        raiseException();
        waitPackets(5);
        returnFromInterrupt();
        waitPackets(4);

        // loop over words already fetched.
        hitsBeforeLoop = hitPackets;
        repeat (4) begin
            branchTo(16'h0004);
            waitPackets(3);
        end

        // halt holds the pc.
        redirect.halt = 1'b1;
        idleCycles(30);
        redirect.halt = 1'b0;
        waitPackets(6);

        if (fillPackets > 0 && hitPackets - hitsBeforeLoop >= 6) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abortRun("the reuse loop did not yield enough packets with cacheHit set");
        end
    end

    // run time limit.
    initial begin
        #(PhaseCount * 2000 * ClkPeriod);
        abortRun("watchdog expired before all phases finished");
    end

endmodule

// ==== fetchUnit.f ====
source/fetchPkg.sv
source/memPkg.sv
source/pcControl.sv
source/instrCache.sv
source/instrBacking.sv
source/fetchIssue.sv
source/fetchTop.sv
tb/fetchTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch unit testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --assert --timescale 1ns/100ps -j 0 \
    --top-module fetchTb -f fetchUnit.f -o fetchSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/fetchSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
    echo "failure reported in $LOG"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi
echo "no failure found in $LOG"
exit 0

// ==== instrRom.hex ====
// one 16-bit instruction word per line.
// first line is word address 0.
9c01
4e12
7a23
0b34
d145
2f56
8c67
5378
e689
1d9a
a4ab
36bc
cbcd
70de
b9ef
45f0
e201
1f92
8a73
3d44
c615
5ba6
0e97
f768
2c39
9dca
64bb
b18c
073d
ca4e
58ff
e3a0
